// File: line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer #(
    parameter int line_w = 256
) (
    input  logic                            clk,
    input  logic                            line_sel,
    input  logic                            wr_en,
    input  logic [tilemap_pkg::XPOS_W-1:0]  wr_addr,
    input  logic [tilemap_pkg::PXL_W-1:0]   wr_pixel,
    input  logic [tilemap_pkg::XPOS_W-1:0]  rd_addr,
    output logic [tilemap_pkg::PXL_W-1:0]   rd_pixel
);

    localparam int AW = $clog2(2 * line_w);

    logic [tilemap_pkg::PXL_W-1:0] mem [0:2*line_w-1];   // bank 1 in the upper half
    logic [AW-1:0]                 wr_idx;
    logic [AW-1:0]                 rd_idx;

    // display reads the bank not being rendered
    assign wr_idx = line_sel ? AW'(line_w) + AW'(wr_addr) : AW'(wr_addr);
    assign rd_idx = line_sel ? AW'(rd_addr) : AW'(line_w) + AW'(rd_addr);

    always_ff @(posedge clk) begin
        if (wr_en && (wr_addr < line_w)) begin
            mem[wr_idx] <= wr_pixel;
        end
        if (rd_addr < line_w) begin
            rd_pixel <= mem[rd_idx];
        end else begin
            rd_pixel <= '0;     // off the line
        end
    end

endmodule

`default_nettype wire

// File: tb_tilemap.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tilemap;

    localparam int line_w      = 256;
    localparam int n_tests     = 8;
    localparam int cycle_limit = 2 * n_tests * 3000;   // two renders per test

    logic        clk = 1'b0;
    logic        rst;
    logic        hs;
    logic        lvbl;
    logic [8:0]  vrender;
    logic [8:0]  hscroll;
    logic [7:0]  vscroll;
    logic        flip;
    logic        txt_en;
    logic        tile_msb;
    logic        pal_msb;
    logic [7:0]  code_sel;
    logic        extra_en;
    logic [3:0]  extra_mask;
    logic [3:0]  extra_bits;
    logic [7:0]  code_scan;
    logic [7:0]  attr_scan;
    logic        rom_ack;
    logic [15:0] rom_data;
    logic [8:0]  rd_addr;
    logic [10:0] scan_addr;
    logic        rom_req;
    logic [17:0] rom_addr;
    logic        done;
    logic [7:0]  rd_pixel;

    logic [7:0]  scan_code [0:2047];
    logic [7:0]  scan_attr [0:2047];
    logic [31:0] lfsr_state = 32'd68182;
    int          cycles = 0;

    tilemap_top #(.line_w(line_w)) i_tilemap_top (
        .clk        (clk),
        .rst        (rst),
        .hs         (hs),
        .lvbl       (lvbl),
        .vrender    (vrender),
        .hscroll    (hscroll),
        .vscroll    (vscroll),
        .flip       (flip),
        .txt_en     (txt_en),
        .tile_msb   (tile_msb),
        .pal_msb    (pal_msb),
        .code_sel   (code_sel),
        .extra_en   (extra_en),
        .extra_mask (extra_mask),
        .extra_bits (extra_bits),
        .code_scan  (code_scan),
        .attr_scan  (attr_scan),
        .rom_ack    (rom_ack),
        .rom_data   (rom_data),
        .rd_addr    (rd_addr),
        .scan_addr  (scan_addr),
        .rom_req    (rom_req),
        .rom_addr   (rom_addr),
        .done       (done),
        .rd_pixel   (rd_pixel)
    );

    always #4 clk = ~clk;

    // asynchronous scan RAM read
    assign code_scan = scan_code[scan_addr];
    assign attr_scan = scan_attr[scan_addr];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            stop_run("timeout: the line renders took longer than the cycle limit");
        end else if (i_tilemap_top.i_ctrl.i_props.fail_count != 0) begin
            stop_run("a bound handshake or done assertion failed");
        end
    end

    // four-phase ROM responder with a random ack delay of 1 to 4 cycles
    initial begin
        int delay;
        rom_ack  = 1'b0;
        rom_data = '0;
        forever begin
            @(negedge clk);
            if (rom_req && !rom_ack) begin
                delay = 1 + int'(rand_bits(2));
                repeat (delay - 1) @(negedge clk);
                rom_data = rom_addr[15:0] ^ 16'h5a3c;
                rom_ack  = 1'b1;
            end else if (!rom_req && rom_ack) begin
                rom_ack = 1'b0;
            end
        end
    end

    // expected pixel at screen position x for the current settings
    function automatic logic [7:0] ref_pixel(input int x);
        logic [8:0]  cnt;
        logic [8:0]  col;
        logic [8:0]  row;
        logic [10:0] saddr;
        logic [7:0]  attr;
        logic [4:0]  bank;
        logic [17:0] addr;
        logic [15:0] word;
        cnt = flip ? 9'(line_w - 1 - x) : 9'(x);
        col = txt_en ? cnt : cnt + hscroll;     // text layer is not scrolled
        row = vrender ^ {9{flip}};
        if (!txt_en) begin
            row = row + {1'b0, vscroll};
        end
        saddr   = {txt_en, row[7:3], col[7:3]};
        attr    = scan_attr[saddr];
        bank[0] = attr[7];
        for (int i = 0; i < 4; i++) begin
            if (extra_en && extra_mask[i]) begin
                bank[i+1] = extra_bits[i];
            end else begin
                bank[i+1] = attr[3 + code_sel[2*i +: 2]];
            end
        end
        addr = {tile_msb, bank, scan_code[saddr], row[2:0], col[2]};
        word = addr[15:0] ^ 16'h5a3c;
        // leftmost pixel sits in the top nibble
        return {pal_msb & attr[3], attr[2:0], word[4 * (3 - col[1:0]) +: 4]};
    endfunction

    task automatic pulse_hs();
        @(negedge clk);
        hs = 1'b1;
        @(negedge clk);
        hs = 1'b0;
    endtask

    task automatic start_line();
        pulse_hs();
        assert (!done) else stop_run("done did not fall after a qualified hs edge");
    endtask

    task automatic wait_done();
        while (!done) @(negedge clk);
    endtask

    task automatic read_back(input string name);
        logic [7:0] exp;
        for (int x = 0; x <= line_w; x++) begin
            @(negedge clk);
            if (x > 0) begin
                exp = ref_pixel(x - 1);
                assert (rd_pixel == exp) else begin
                    $display("[FAIL] %s pixel %0d expected %02h actual %02h",
                             name, x - 1, exp, rd_pixel);
                    stop_run("line buffer read-back mismatch");
                end
            end
            if (x < line_w) begin
                rd_addr = 9'(x);
            end
        end
    endtask

    // render, then swap banks with a second render and read the first one back
    task automatic run_line(input string name);
        start_line();
        wait_done();
        start_line();
        read_back(name);
        wait_done();
    endtask

    task automatic pick_scroll();
        vrender    = 9'(rand_bits(9));
        hscroll    = 9'(rand_bits(9));
        vscroll    = 8'(rand_bits(8));
        code_sel   = 8'(rand_bits(8));
        tile_msb   = 1'(rand_bits(1));
        pal_msb    = 1'(rand_bits(1));
        extra_bits = 4'(rand_bits(4));
    endtask

    initial begin
        rst        = 1'b1;
        hs         = 1'b0;
        lvbl       = 1'b1;
        vrender    = '0;
        hscroll    = '0;
        vscroll    = '0;
        flip       = 1'b0;
        txt_en     = 1'b0;
        tile_msb   = 1'b0;
        pal_msb    = 1'b0;
        code_sel   = '0;
        extra_en   = 1'b0;
        extra_mask = '0;
        extra_bits = '0;
        rd_addr    = '0;
        for (int a = 0; a < 2048; a++) begin
            scan_code[a] = 8'(rand_bits(8));
            scan_attr[a] = 8'(rand_bits(8));
        end

        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (done && !rom_req) else stop_run("done low or rom_req high after reset");

        // hs outside active video must not start a line
        lvbl = 1'b0;
        pulse_hs();
        repeat (4) @(negedge clk);
        assert (done && !rom_req) else stop_run("a line started while lvbl was low");
        lvbl = 1'b1;

        vrender = 9'd40;
        pal_msb = 1'b1;
        run_line("plain");

        for (int i = 0; i < 3; i++) begin
            pick_scroll();
            run_line($sformatf("scroll_%0d", i));
        end

        pick_scroll();
        flip = 1'b1;
        run_line("flip");

        pick_scroll();
        flip   = 1'b0;
        txt_en = 1'b1;      // scroll values picked above must be ignored
        run_line("text");

        pick_scroll();
        txt_en     = 1'b0;
        extra_en   = 1'b1;
        extra_mask = 4'b0101;
        run_line("bank_mask");

        pick_scroll();
        extra_mask = 4'b1111;
        run_line("bank_all");

        if (i_tilemap_top.i_ctrl.i_props.fail_count == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            stop_run("a bound handshake or done assertion failed");
        end
    end

endmodule

`default_nettype wire

// File: tb_tilemap_props.sv
`timescale 1ns/1ns
`default_nettype none

module tb_tilemap_props (
    input logic                      clk,
    input logic                      rst,
    input logic                      hs,
    input logic                      lvbl,
    input logic                      done,
    input logic                      rom_req,
    input logic                      rom_ack,
    input tilemap_pkg::tile_state_t  state
);

    int fail_count = 0;     // polled by the testbench every cycle

    // a new request only once the previous ack has been seen low
    req_rise_ack_low: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_req) |-> !$past(rom_ack))
    else begin
        fail_count++;
        $error("rom_req rose while rom_ack was still high");
    end

    req_hold: assert property (@(posedge clk) disable iff (rst)
        rom_req && !rom_ack |=> rom_req)    // request held until acked
    else begin
        fail_count++;
        $error("rom_req dropped before rom_ack rose");
    end

    req_release: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_ack) |-> ##[0:1] !rom_req)
    else begin
        fail_count++;
        $error("rom_req still high one cycle after rom_ack rose");
    end

    done_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> done)
    else begin
        fail_count++;
        $error("done low right after reset");
    end

    // idle is left only on a qualified hs edge
    idle_needs_hs: assert property (@(posedge clk) disable iff (rst)
        (state == tilemap_pkg::st_idle) && !($rose(hs) && lvbl)
        |=> state == tilemap_pkg::st_idle)
    else begin
        fail_count++;
        $error("FSM left idle without an hs edge in active video");
    end

endmodule

bind tilemap_ctrl tb_tilemap_props i_props (
    .clk     (clk),
    .rst     (rst),
    .hs      (hs),
    .lvbl    (lvbl),
    .done    (done),
    .rom_req (rom_req),
    .rom_ack (rom_ack),
    .state   (state)
);

`default_nettype wire

// File: tile_attr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module tile_attr_decode (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            attr_load,
    input  logic [7:0]                      code_scan,
    input  logic [7:0]                      attr_scan,
    input  logic [7:0]                      code_sel,    // four 2-bit selectors
    input  logic                            extra_en,
    input  logic [3:0]                      extra_mask,
    input  logic [3:0]                      extra_bits,
    input  logic                            pal_msb,
    output logic [tilemap_pkg::CODE_W-1:0]  code,
    output logic [tilemap_pkg::PAL_W-1:0]   pal
);

    localparam int BANK_W = tilemap_pkg::CODE_W - 8;

    logic [BANK_W-1:0] bank;

    // bank bits 1 to 4 pick one of attr bits 3..6 unless overridden
    always_comb begin
        bank[0] = attr_scan[7];
        for (int i = 0; i < BANK_W - 1; i++) begin
            if (extra_en && extra_mask[i]) begin
                bank[i+1] = extra_bits[i];
            end else begin
                bank[i+1] = attr_scan[3 + code_sel[2*i +: 2]];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            code <= '0;
            pal  <= '0;
        end else if (attr_load) begin
            code <= {bank, code_scan};
            pal  <= {pal_msb & attr_scan[3], attr_scan[2:0]};
        end
    end

endmodule

`default_nettype wire

// File: tile_pixel_dump.sv
`timescale 1ns/1ns
`default_nettype none

module tile_pixel_dump #(
    parameter int line_w = 256
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load_h,
    input  logic [tilemap_pkg::XPOS_W-1:0]  hscroll,
    input  logic                            txt_en,
    input  logic                            flip,
    input  logic                            word_load,
    input  logic [tilemap_pkg::ROM_DW-1:0]  rom_data,
    input  logic                            shift_en,
    input  logic [tilemap_pkg::PAL_W-1:0]   pal,
    output logic                            wr_en,
    output logic [tilemap_pkg::XPOS_W-1:0]  wr_addr,
    output logic [tilemap_pkg::PXL_W-1:0]   wr_pixel,
    output logic                            line_end
);

    // two spare bits so the counter can sit below zero and still reach 512
    localparam int CNT_W = tilemap_pkg::XPOS_W + 2;

    logic [CNT_W-1:0]                cnt;
    logic [tilemap_pkg::ROM_DW-1:0]  pxl_data;
    logic                            in_line;
    logic [tilemap_pkg::XPOS_W-1:0]  flip_addr;

    assign in_line   = !cnt[CNT_W-1] && (cnt < line_w);
    assign line_end  = !cnt[CNT_W-1] && (cnt >= line_w);
    assign flip_addr = tilemap_pkg::XPOS_W'(line_w - 1) - cnt[tilemap_pkg::XPOS_W-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt   <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= shift_en && in_line;   // pre-roll pixels are dropped
            if (load_h) begin
                // fine scroll starts left of the screen edge
                cnt <= txt_en ? '0 : '0 - {{(CNT_W-2){1'b0}}, hscroll[1:0]};
            end else if (shift_en) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_load) begin
            pxl_data <= rom_data;
        end else if (shift_en) begin
            pxl_data <= pxl_data << tilemap_pkg::COLOR_W;
        end
        if (shift_en) begin
            wr_pixel <= {pal, pxl_data[tilemap_pkg::ROM_DW-1 -: tilemap_pkg::COLOR_W]};
            wr_addr  <= flip ? flip_addr : cnt[tilemap_pkg::XPOS_W-1:0];
        end
    end

endmodule

`default_nettype wire

// File: tile_scroll_addr.sv
`timescale 1ns/1ns
`default_nettype none

module tile_scroll_addr (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_h,
    input  logic                             vn_load,
    input  logic                             col_step,
    input  logic [tilemap_pkg::XPOS_W-1:0]   vrender,
    input  logic [tilemap_pkg::XPOS_W-1:0]   hscroll,
    input  logic [7:0]                       vscroll,
    input  logic                             flip,
    input  logic                             txt_en,
    input  logic                             tile_msb,
    input  logic [tilemap_pkg::CODE_W-1:0]   code,
    output logic [tilemap_pkg::SCAN_AW-1:0]  scan_addr,
    output logic [tilemap_pkg::ROM_AW-1:0]   rom_addr,
    output logic                             col_half
);

    logic [tilemap_pkg::XPOS_W-1:0] hn;      // map column
    logic [tilemap_pkg::XPOS_W-1:0] vn;      // map row
    logic [tilemap_pkg::XPOS_W-1:0] vn_next;

    // text layer has no vertical scroll
    always_comb begin
        vn_next = vrender ^ {tilemap_pkg::XPOS_W{flip}};
        if (!txt_en) begin
            vn_next = vn_next + {1'b0, vscroll};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hn <= '0;
            vn <= '0;
        end else begin
            if (load_h) begin
                hn <= txt_en ? '0 : hscroll;
            end else if (col_step) begin
                hn <= hn + 9'd4;    // half a tile per ROM word
            end
            if (vn_load) begin
                vn <= vn_next;
            end
        end
    end

    assign scan_addr = {txt_en, vn[7:3], hn[7:3]};
    assign rom_addr  = {tile_msb, code, vn[2:0], hn[2]};
    assign col_half  = hn[2];

endmodule

`default_nettype wire

// File: tilemap_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tilemap_ctrl #(
    parameter int line_w = 256
) (
    input  logic clk,
    input  logic rst,
    input  logic hs,
    input  logic lvbl,
    input  logic col_half,
    input  logic line_end,
    output logic done,
    output logic line_sel,
    output logic col_step,
    output logic vn_load,
    output logic load_h,
    output logic attr_load,
    output logic word_load,
    output logic shift_en,
    output logic rom_req,
    input  logic rom_ack
);

    // one extra word covers the fine scroll pre-roll
    localparam int WORDS = line_w / 4 + 1;
    localparam int WC_W  = $clog2(WORDS + 1);

    tilemap_pkg::tile_state_t state;

    logic            hs_l;
    logic            start;
    logic [1:0]      dump_cnt;
    logic [WC_W-1:0] words_left;
    logic            finish;

    assign start  = hs && !hs_l && lvbl;
    assign finish = line_end || (words_left == '0);

    // datapath strobes
    assign load_h    = (state == tilemap_pkg::st_idle) && start;
    assign vn_load   = (state == tilemap_pkg::st_idle) && start;
    assign attr_load = (state == tilemap_pkg::st_attr);
    assign word_load = (state == tilemap_pkg::st_wait) && rom_ack;
    assign shift_en  = (state == tilemap_pkg::st_dump);
    assign col_step  = (state == tilemap_pkg::st_next) && !rom_ack && !finish;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= tilemap_pkg::st_idle;
            done       <= 1'b1;
            line_sel   <= 1'b0;
            rom_req    <= 1'b0;
            hs_l       <= 1'b0;
            dump_cnt   <= '0;
            words_left <= '0;
        end else begin
            hs_l <= hs;
            case (state)
                tilemap_pkg::st_idle: begin
                    if (start) begin
                        line_sel   <= ~line_sel;    // swap render and display banks
                        done       <= 1'b0;
                        words_left <= WC_W'(WORDS);
                        state      <= tilemap_pkg::st_scan;
                    end
                end
                tilemap_pkg::st_scan: state <= tilemap_pkg::st_attr;
                tilemap_pkg::st_attr: state <= tilemap_pkg::st_req;
                tilemap_pkg::st_req: begin
                    if (!rom_ack) begin     // previous cycle fully closed
                        rom_req <= 1'b1;
                        state   <= tilemap_pkg::st_wait;
                    end
                end
                tilemap_pkg::st_wait: begin
                    if (rom_ack) begin
                        rom_req    <= 1'b0;
                        words_left <= words_left - 1'b1;
                        dump_cnt   <= '0;
                        state      <= tilemap_pkg::st_dump;
                    end
                end
                tilemap_pkg::st_dump: begin
                    dump_cnt <= dump_cnt + 1'b1;
                    if (dump_cnt == 2'd3) begin
                        state <= tilemap_pkg::st_next;
                    end
                end
                tilemap_pkg::st_next: begin
                    // address must stay put until the ROM drops ack
                    if (!rom_ack) begin
                        if (finish) begin
                            done  <= 1'b1;
                            state <= tilemap_pkg::st_idle;
                        end else if (col_half) begin
                            state <= tilemap_pkg::st_scan;   // next tile
                        end else begin
                            state <= tilemap_pkg::st_req;    // right half of the same tile
                        end
                    end
                end
                default: state <= tilemap_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: tilemap_pkg.sv
`default_nettype none

package tilemap_pkg;

    // line FSM walked once per scan line
    typedef enum logic [2:0] {
        st_idle,    // waiting for hs
        st_scan,    // scan_addr settling
        st_attr,    // code and attribute sampled
        st_req,
        st_wait,    // ROM busy
        st_dump,    // four pixels out
        st_next
    } tile_state_t;

    localparam int CODE_W  = 13;            // bank bits + scan code
    localparam int PAL_W   = 4;

    // line buffer pixel is {pal, colour}
    localparam int PXL_W   = 8;
    localparam int COLOR_W = PXL_W - PAL_W;

    // graphics ROM word holds four pixels with the leftmost in the top nibble
    localparam int ROM_DW  = 16;
    localparam int ROM_AW  = 18;

    localparam int SCAN_AW = 11;            // text flag + 5 row + 5 column bits
    localparam int XPOS_W  = 9;             // row and column counters

endpackage

`default_nettype wire

// File: tilemap_top.sv
`timescale 1ns/1ns
`default_nettype none

module tilemap_top #(
    parameter int line_w = 256
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hs,
    input  logic                             lvbl,
    input  logic [tilemap_pkg::XPOS_W-1:0]   vrender,
    input  logic [tilemap_pkg::XPOS_W-1:0]   hscroll,
    input  logic [7:0]                       vscroll,
    input  logic                             flip,
    input  logic                             txt_en,
    input  logic                             tile_msb,
    input  logic                             pal_msb,
    input  logic [7:0]                       code_sel,
    input  logic                             extra_en,
    input  logic [3:0]                       extra_mask,
    input  logic [3:0]                       extra_bits,
    input  logic [7:0]                       code_scan,
    input  logic [7:0]                       attr_scan,
    input  logic                             rom_ack,
    input  logic [tilemap_pkg::ROM_DW-1:0]   rom_data,
    input  logic [tilemap_pkg::XPOS_W-1:0]   rd_addr,
    output logic [tilemap_pkg::SCAN_AW-1:0]  scan_addr,
    output logic                             rom_req,
    output logic [tilemap_pkg::ROM_AW-1:0]   rom_addr,
    output logic                             done,
    output logic [tilemap_pkg::PXL_W-1:0]    rd_pixel
);

    logic                            line_sel;
    logic                            col_step;
    logic                            vn_load;
    logic                            load_h;
    logic                            attr_load;
    logic                            word_load;
    logic                            shift_en;
    logic                            col_half;
    logic                            line_end;
    logic [tilemap_pkg::CODE_W-1:0]  code;
    logic [tilemap_pkg::PAL_W-1:0]   pal;
    logic                            wr_en;
    logic [tilemap_pkg::XPOS_W-1:0]  wr_addr;
    logic [tilemap_pkg::PXL_W-1:0]   wr_pixel;

    tilemap_ctrl #(.line_w(line_w)) i_ctrl (
        .clk       (clk),
        .rst       (rst),
        .hs        (hs),
        .lvbl      (lvbl),
        .col_half  (col_half),
        .line_end  (line_end),
        .done      (done),
        .line_sel  (line_sel),
        .col_step  (col_step),
        .vn_load   (vn_load),
        .load_h    (load_h),
        .attr_load (attr_load),
        .word_load (word_load),
        .shift_en  (shift_en),
        .rom_req   (rom_req),
        .rom_ack   (rom_ack)
    );

    tile_scroll_addr i_scroll (
        .clk       (clk),
        .rst       (rst),
        .load_h    (load_h),
        .vn_load   (vn_load),
        .col_step  (col_step),
        .vrender   (vrender),
        .hscroll   (hscroll),
        .vscroll   (vscroll),
        .flip      (flip),
        .txt_en    (txt_en),
        .tile_msb  (tile_msb),
        .code      (code),
        .scan_addr (scan_addr),
        .rom_addr  (rom_addr),
        .col_half  (col_half)
    );

    tile_attr_decode i_attr (
        .clk        (clk),
        .rst        (rst),
        .attr_load  (attr_load),
        .code_scan  (code_scan),
        .attr_scan  (attr_scan),
        .code_sel   (code_sel),
        .extra_en   (extra_en),
        .extra_mask (extra_mask),
        .extra_bits (extra_bits),
        .pal_msb    (pal_msb),
        .code       (code),
        .pal        (pal)
    );

    tile_pixel_dump #(.line_w(line_w)) i_dump (
        .clk       (clk),
        .rst       (rst),
        .load_h    (load_h),
        .hscroll   (hscroll),
        .txt_en    (txt_en),
        .flip      (flip),
        .word_load (word_load),
        .rom_data  (rom_data),
        .shift_en  (shift_en),
        .pal       (pal),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_pixel  (wr_pixel),
        .line_end  (line_end)
    );

    line_buffer #(.line_w(line_w)) i_lbuf (
        .clk      (clk),
        .line_sel (line_sel),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_pixel (wr_pixel),
        .rd_addr  (rd_addr),
        .rd_pixel (rd_pixel)
    );

endmodule

`default_nettype wire

// File: vlog.f
tilemap_pkg.sv
tile_scroll_addr.sv
tile_attr_decode.sv
tile_pixel_dump.sv
line_buffer.sv
tilemap_ctrl.sv
tilemap_top.sv
tb_tilemap_props.sv
tb_tilemap.sv
